// File: verilog/spi_ram_pkg.sv
////////////////////////////////////////////////////////////
// spi ram bridge shared types and frame constants
// frame: cmd byte, 16-bit address msb first, data bytes
// read frames carry one dummy byte before the data
////////////////////////////////////////////////////////////

`default_nettype none

package spi_ram_pkg;

  localparam int unsigned BYTE_W = 8;   // spi shift and ram word width
  localparam int unsigned ADDR_W = 16;  // address field in the frame
  localparam int unsigned CNT_W  = 6;   // header count plus data phase flag

  // data byte on the shift path and ram ports
  typedef logic [BYTE_W-1:0] byte_t;

  // full frame address, ram uses the low bits only
  typedef logic [ADDR_W-1:0] addr_t;

  // frame bit counter, msb set once the header is in
  typedef logic [CNT_W-1:0] bit_cnt_t;

  // cmd byte + two address bytes
  localparam int unsigned HDR_BITS = BYTE_W + ADDR_W;

  // command bytes, slave decodes bit 0 only
  localparam byte_t CMD_WRITE = 8'h00;
  localparam byte_t CMD_READ  = 8'h01;

endpackage : spi_ram_pkg

`default_nettype wire

// File: verilog/spi_rw_slave.sv
////////////////////////////////////////////////////////////
// spi mode 0 slave with ram read/write requests
// sclk, mosi and ss are oversampled by clk (>= 8x sclk)
// write: 00 addr_hi addr_lo data...
// read:  01 addr_hi addr_lo dummy data...
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spi_rw_slave
  import spi_ram_pkg::*;
#(
  parameter int unsigned MEM_AW = 10  // ram address width, 4..16
)
(
  input  wire              clk,
  input  wire              csn,     // async reset, active high
  input  wire              sclk,    // spi clock, generic pin
  input  wire              mosi,
  input  wire              ss,      // spi select, active low
  output logic             miso,
  output logic             miso_oe, // pad enable, select active
  output logic             rd,      // one clk read request
  output logic             wr,      // one clk write request
  output logic [MEM_AW-1:0] addr,
  output byte_t            wdata,
  input  wire byte_t       rdata    // valid clk after rd
);

  // two flop synchronizers, bit 1 is the usable side
  logic [1:0] sclk_sync;
  logic [1:0] mosi_sync;
  logic [1:0] ss_sync;
  logic       sclk_d;     // delayed sclk for edge detect

  logic sclk_s;
  logic mosi_s;
  logic ss_s;
  logic sclk_rise;

  // frame state
  bit_cnt_t bit_cnt;      // 23..0 in header, then msb set
  byte_t    shift_q;      // shared in/out shift register
  logic     cmd_rd;       // bit 0 of the command byte
  addr_t    addr_q;       // frame address, steps per data byte

  // per edge strobes
  logic hdr_bit;          // edge inside cmd/addr header
  logic dat_bit;          // edge inside data phase
  logic rd_frame;
  logic byte_end;         // last bit of a data byte
  logic step_addr;        // first bit of 2nd and later data bytes
  logic rd_req;
  logic wr_req;

  assign sclk_s = sclk_sync[1];
  assign mosi_s = mosi_sync[1];
  assign ss_s   = ss_sync[1];

  assign sclk_rise = sclk_s & ~sclk_d;  // one clk after sync output rises

  always_ff @(posedge clk or posedge csn)
  begin
    if (csn)
    begin
      sclk_sync <= 2'b00;
      mosi_sync <= 2'b00;
      ss_sync   <= 2'b11;   // deselected out of reset
      sclk_d    <= 1'b0;
    end
    else
    begin
      sclk_sync <= {sclk_sync[0], sclk};
      mosi_sync <= {mosi_sync[0], mosi};
      ss_sync   <= {ss_sync[0], ss};
      sclk_d    <= sclk_s;
    end
  end

  assign rd_frame = (cmd_rd == CMD_READ[0]);

  assign hdr_bit   = ~ss_s & sclk_rise & ~bit_cnt[CNT_W-1];
  assign dat_bit   = ~ss_s & sclk_rise &  bit_cnt[CNT_W-1];
  assign byte_end  = dat_bit & (bit_cnt[2:0] == 3'd0);
  // bit 3 stays set through the first data byte, so no step there
  assign step_addr = dat_bit & (bit_cnt[3:0] == 4'd7);
  // one sclk before the last bit, data is back before byte_end
  assign rd_req    = dat_bit & rd_frame & (bit_cnt[2:0] == 3'd1);
  assign wr_req    = byte_end & ~rd_frame;

  // bit counter and request pulses
  always_ff @(posedge clk or posedge csn)
  begin
    if (csn)
    begin
      bit_cnt <= bit_cnt_t'(HDR_BITS - 1);
      rd      <= 1'b0;
      wr      <= 1'b0;
    end
    else
    begin
      rd <= rd_req;       // single clk pulses
      wr <= wr_req;
      if (ss_s)
      begin
        bit_cnt <= bit_cnt_t'(HDR_BITS - 1);  // deselect drops the frame
      end
      else if (hdr_bit)
      begin
        bit_cnt <= bit_cnt - 1'b1;   // 0 wraps to all ones, data phase
      end
      else if (dat_bit)
      begin
        bit_cnt[2:0] <= bit_cnt[2:0] - 1'b1;
        if (byte_end)
          bit_cnt[3] <= 1'b0;       // enable stepping from next byte on
      end
    end
  end

  // shift path and address register
  always_ff @(posedge clk)
  begin
    if (~ss_s && sclk_rise)
    begin
      if (byte_end && rd_frame)
        shift_q <= rdata;           // next byte to send
      else
        shift_q <= {shift_q[BYTE_W-2:0], mosi_s};
    end
    if (hdr_bit)
    begin
      // 24 bits in, 17 kept: cmd bit 0 ends up on top
      {cmd_rd, addr_q} <= {addr_q, mosi_s};
    end
    else if (step_addr)
    begin
      addr_q <= addr_q + 1'b1;
    end
  end

  assign addr  = addr_q[MEM_AW-1:0];   // ram wraps on its depth
  assign wdata = shift_q;              // full byte while wr is high

  // miso moves only after rising sclk, so mode 0 sampling is safe
  assign miso_oe = ~ss_s;
  assign miso    = ~ss_s & shift_q[BYTE_W-1];

  // ram sees one request kind at a time
  a_rd_wr_excl : assert property (@(posedge clk) disable iff (csn) !(rd && wr))
    else $error("spi_rw_slave: rd and wr high together");

  // a write only comes out of a selected frame
  a_wr_selected : assert property (@(posedge clk) disable iff (csn) wr |-> !ss_s)
    else $error("spi_rw_slave: wr while ss high");

endmodule : spi_rw_slave

`default_nettype wire

// File: verilog/spi_dp_ram.sv
////////////////////////////////////////////////////////////
// dual port byte ram for the spi bridge
// spi port and local port, both with registered reads
// local write wins on a same word collision
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spi_dp_ram
  import spi_ram_pkg::*;
#(
  parameter int unsigned MEM_AW = 10  // 2**MEM_AW bytes
)
(
  input  wire               clk,
  // spi slave side
  input  wire [MEM_AW-1:0]  spi_addr,
  input  wire               spi_we,
  input  wire byte_t        spi_wdata,
  input  wire               spi_re,
  output byte_t             spi_rdata,   // holds between reads
  // local side
  input  wire [MEM_AW-1:0]  loc_addr,
  input  wire               loc_we,
  input  wire byte_t        loc_wdata,
  output byte_t             loc_rdata    // one clk latency
);

  localparam int unsigned DEPTH = 2 ** MEM_AW;

  byte_t mem [DEPTH];

  // writes, later assignment takes priority
  always_ff @(posedge clk)
  begin
    if (spi_we)
      mem[spi_addr] <= spi_wdata;
    if (loc_we)
      mem[loc_addr] <= loc_wdata;   // local port wins
  end

  // spi read only on request
  always_ff @(posedge clk)
  begin
    if (spi_re)
      spi_rdata <= mem[spi_addr];
  end

  // local read every clk
  always_ff @(posedge clk)
  begin
    loc_rdata <= mem[loc_addr];
  end

  // slave never reads and writes in one request
  a_spi_we_re : assert property (@(posedge clk) !(spi_we && spi_re))
    else $error("spi_dp_ram: spi_we and spi_re high together");

endmodule : spi_dp_ram

`default_nettype wire

// File: verilog/spi_ram_bridge.sv
////////////////////////////////////////////////////////////
// spi to ram bridge top
// spi slave drives the ram, local port exposed for
// preload and readback by on-chip logic
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spi_ram_bridge
  import spi_ram_pkg::*;
#(
  parameter int unsigned MEM_AW = 10  // ram address width, 4..16
)
(
  input  wire               clk,
  input  wire               csn,        // async reset, active high
  // spi pins
  input  wire               sclk,
  input  wire               mosi,
  input  wire               ss,         // active low select
  output logic              miso,
  output logic              miso_oe,    // to the pad tristate
  // local ram port
  input  wire [MEM_AW-1:0]  loc_addr,
  input  wire               loc_we,
  input  wire byte_t        loc_wdata,
  output byte_t             loc_rdata   // one clk after loc_addr
);

  // slave to ram requests
  logic              rd;
  logic              wr;
  logic [MEM_AW-1:0] addr;
  byte_t             wdata;
  byte_t             rdata;

  spi_rw_slave #(
    .MEM_AW  (MEM_AW)
  ) u_slave (
    .clk     (clk),
    .csn     (csn),
    .sclk    (sclk),
    .mosi    (mosi),
    .ss      (ss),
    .miso    (miso),
    .miso_oe (miso_oe),
    .rd      (rd),
    .wr      (wr),
    .addr    (addr),
    .wdata   (wdata),
    .rdata   (rdata)
  );

  spi_dp_ram #(
    .MEM_AW    (MEM_AW)
  ) u_ram (
    .clk       (clk),
    .spi_addr  (addr),
    .spi_we    (wr),
    .spi_wdata (wdata),
    .spi_re    (rd),
    .spi_rdata (rdata),
    .loc_addr  (loc_addr),
    .loc_we    (loc_we),
    .loc_wdata (loc_wdata),
    .loc_rdata (loc_rdata)
  );

endmodule : spi_ram_bridge

`default_nettype wire

// File: tests/tb_clk_gen.sv
////////////////////////////////////////////////////////////
// testbench clock and reset source
// 40 ns clock, reset held high for the first 10 cycles
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_NS      = 20,  // half of the 40 ns period
  parameter int RESET_CYCLES = 10
)
(
  output logic clk,
  output logic csn   // active high system reset
);

  initial
  begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

  // release on a falling edge, away from the sampling edge
  initial
  begin
    csn = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    csn = 1'b0;
  end

endmodule : tb_clk_gen

`default_nettype wire

// File: tests/tb_spi_ram_bridge.sv
////////////////////////////////////////////////////////////
// testbench for the spi to ram bridge
// spi mode 0 master, local port access, shadow ram model
// directed tests with lfsr data and one report line per test
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_spi_ram_bridge
  import spi_ram_pkg::*;
();

  localparam int MEM_AW      = 10;
  localparam int DEPTH       = 2 ** MEM_AW;
  localparam int TIMEOUT_CLK = 20000;  // ~60 spi bytes x 64 clk plus ram fill and margin
  localparam logic [31:0] LFSR_SEED = 32'hc639_2830;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32+x^22+x^2+x+1

  logic              clk;
  logic              csn;
  logic              sclk;
  logic              mosi;
  logic              ss;
  logic              miso;
  logic              miso_oe;
  logic [MEM_AW-1:0] loc_addr;
  logic              loc_we;
  byte_t             loc_wdata;
  byte_t             loc_rdata;

  byte_t shadow [0:DEPTH-1];   // reference copy of the ram
  byte_t tx_buf [0:15];        // data bytes of the next frame
  byte_t rx_buf [0:15];        // bytes seen on miso

  logic [31:0]       lfsr;
  int                err_cnt;
  int                test_cnt;
  int                pass_cnt;
  int                cycle_cnt;
  int                frame_bit;  // bit index within the current frame
  int                hit_bit;    // frame bit that gets a colliding local write
  logic [MEM_AW-1:0] hit_addr;
  byte_t             hit_data;

  tb_clk_gen u_clk_gen (
    .clk (clk),
    .csn (csn)
  );

  spi_ram_bridge #(
    .MEM_AW    (MEM_AW)
  ) u_spi_ram_bridge (
    .clk       (clk),
    .csn       (csn),
    .sclk      (sclk),
    .mosi      (mosi),
    .ss        (ss),
    .miso      (miso),
    .miso_oe   (miso_oe),
    .loc_addr  (loc_addr),
    .loc_we    (loc_we),
    .loc_wdata (loc_wdata),
    .loc_rdata (loc_rdata)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // ram fill pattern over every address bit
  function automatic byte_t fill_byte(input logic [MEM_AW-1:0] a);
    return a[7:0] ^ {4{a[9:8]}};
  endfunction

  task automatic random_byte(output byte_t b);
    int i;
    for (i = 0; i < 8; i++)
    begin
      lfsr = lfsr_next(lfsr);   // one step per bit
      b = {b[6:0], lfsr[0]};
    end
  endtask

  task automatic flag_mismatch(input string name, input logic [MEM_AW-1:0] a,
                               input byte_t exp, input byte_t got);
    $display("mismatch %s addr 0x%03h: expected 0x%02h, got 0x%02h", name, a, exp, got);
    err_cnt++;
  endtask

  task automatic close_test(input string name, input int start_err);
    test_cnt++;
    if (err_cnt == start_err)
    begin
      pass_cnt++;
      $display("test %-16s ok", name);
    end
    else
      $display("test %-16s failed, %0d errors", name, err_cnt - start_err);
  endtask

  // local port access between falling edges
  task automatic local_write(input logic [MEM_AW-1:0] a, input byte_t d);
    loc_addr  = a;
    loc_wdata = d;
    loc_we    = 1'b1;
    @(negedge clk);
    loc_we    = 1'b0;
    shadow[a] = d;
  endtask

  task automatic local_read(input logic [MEM_AW-1:0] a, output byte_t d);
    loc_addr = a;
    @(negedge clk);           // one clk read latency
    d = loc_rdata;
  endtask

  task automatic verify_word(input logic [MEM_AW-1:0] a);
    byte_t got;
    local_read(a, got);
    if (got !== shadow[a])
      flag_mismatch("loc_rdata", a, shadow[a], got);
  endtask

  task automatic fill_ram;
    int a;
    for (a = 0; a < DEPTH; a++)
    begin
      loc_addr  = MEM_AW'(a);
      loc_wdata = fill_byte(MEM_AW'(a));
      loc_we    = 1'b1;
      shadow[a] = fill_byte(MEM_AW'(a));
      @(negedge clk);
    end
    loc_we = 1'b0;
  endtask

  // one sclk period of 8 clk with mosi set in the low half
  task automatic xfer_bit(input logic b, output logic s);
    sclk = 1'b0;
    mosi = b;
    repeat (4) @(negedge clk);
    s    = miso;               // just before the rising edge
    sclk = 1'b1;
    // wr goes high in the 3rd clk after the pin via 2 sync flops and edge detect
    repeat (3) @(negedge clk);
    if (frame_bit == hit_bit)
    begin
      loc_addr  = hit_addr;
      loc_wdata = hit_data;
      loc_we    = 1'b1;        // same ram edge as wr
    end
    @(negedge clk);
    loc_we = 1'b0;
    frame_bit++;
  endtask

  task automatic xfer_byte(input byte_t tx, output byte_t rx);
    logic s;
    int   i;
    for (i = 7; i >= 0; i--)
    begin
      xfer_bit(tx[i], s);      // msb first
      rx = {rx[6:0], s};
    end
  endtask

  task automatic select_slave;
    ss = 1'b0;
    repeat (4) @(negedge clk);
    frame_bit = 0;
  endtask

  task automatic release_slave;
    sclk = 1'b0;
    repeat (4) @(negedge clk);
    ss = 1'b1;
    repeat (8) @(negedge clk); // let ss pass the synchronizer
  endtask

  task automatic send_header(input byte_t cmd, input addr_t a);
    byte_t rx;
    xfer_byte(cmd, rx);
    xfer_byte(a[15:8], rx);
    xfer_byte(a[7:0], rx);
  endtask

  // n full bytes then cut_bits of tx_buf[n] before deselect
  task automatic send_write_frame(input addr_t a, input int n, input int cut_bits);
    byte_t             rx;
    logic              s;
    logic [MEM_AW-1:0] wa;
    int                k;
    select_slave();
    send_header(CMD_WRITE, a);
    for (k = 0; k < n; k++)
      xfer_byte(tx_buf[k], rx);
    for (k = 0; k < cut_bits; k++)
      xfer_bit(tx_buf[n][7-k], s);
    release_slave();
    // byte k lands at a+k modulo the ram depth
    for (k = 0; k < n; k++)
    begin
      wa = a[MEM_AW-1:0] + MEM_AW'(k);
      shadow[wa] = tx_buf[k];
    end
  endtask

  task automatic send_read_frame(input addr_t a, input int n);
    byte_t rx;
    int    k;
    select_slave();
    send_header(CMD_READ, a);
    xfer_byte(8'h00, rx);      // dummy byte while the ram fetches a
    for (k = 0; k < n; k++)
    begin
      xfer_byte(8'h00, rx);
      rx_buf[k] = rx;
    end
    release_slave();
  endtask

  task automatic check_reset_state;
    int start_err;
    int i;
    start_err = err_cnt;
    repeat (2) @(negedge clk);
    if (miso_oe !== 1'b0)
    begin
      $display("mismatch miso_oe in reset: expected 0x0, got 0x%0h", miso_oe);
      err_cnt++;
    end
    while (csn === 1'b1)
      @(negedge clk);
    repeat (4) @(negedge clk);
    if (miso_oe !== 1'b0 || miso !== 1'b0)
    begin
      $display("mismatch miso_oe/miso after reset: expected 0x0/0x0, got 0x%0h/0x%0h",
               miso_oe, miso);
      err_cnt++;
    end
    // sclk activity while deselected
    for (i = 0; i < 4; i++)
    begin
      sclk = 1'b1;
      repeat (4) @(negedge clk);
      sclk = 1'b0;
      repeat (4) @(negedge clk);
      if (miso_oe !== 1'b0)
      begin
        $display("mismatch miso_oe with ss high: expected 0x0, got 0x%0h", miso_oe);
        err_cnt++;
      end
    end
    ss = 1'b0;
    repeat (4) @(negedge clk);
    if (miso_oe !== 1'b1)
    begin
      $display("mismatch miso_oe with ss low: expected 0x1, got 0x%0h", miso_oe);
      err_cnt++;
    end
    ss = 1'b1;
    repeat (4) @(negedge clk);
    if (miso_oe !== 1'b0)
    begin
      $display("mismatch miso_oe after deselect: expected 0x0, got 0x%0h", miso_oe);
      err_cnt++;
    end
    close_test("reset_state", start_err);
  endtask

  task automatic single_write;
    int                start_err;
    byte_t             hi;
    byte_t             lo;
    logic [MEM_AW-1:0] wa;
    start_err = err_cnt;
    random_byte(hi);
    random_byte(lo);
    random_byte(tx_buf[0]);
    send_write_frame({hi, lo}, 1, 0);
    wa = lo | (MEM_AW'(hi) << 8);  // low MEM_AW bits select the word
    verify_word(wa);
    verify_word(wa + 1'b1);        // neighbor keeps its fill
    close_test("single_write", start_err);
  endtask

  task automatic burst_write_wrap;
    int                start_err;
    int                k;
    logic [MEM_AW-1:0] wa;
    start_err = err_cnt;
    for (k = 0; k < 8; k++)
      random_byte(tx_buf[k]);
    send_write_frame(16'hf3fc, 8, 0);  // 0x3fc..0x003 with upper bits dropped
    wa = 10'h3fb;
    for (k = 0; k < 10; k++)
    begin
      verify_word(wa);
      wa = wa + 1'b1;
    end
    close_test("burst_write_wrap", start_err);
  endtask

  task automatic burst_read;
    int                start_err;
    int                k;
    byte_t             d;
    logic [MEM_AW-1:0] wa;
    start_err = err_cnt;
    for (k = 0; k < 6; k++)
    begin
      random_byte(d);
      local_write(10'h123 + MEM_AW'(k), d);
    end
    send_read_frame(16'h4123, 6);
    for (k = 0; k < 6; k++)
    begin
      wa = 10'h123 + MEM_AW'(k);
      if (rx_buf[k] !== shadow[wa])
        flag_mismatch("miso byte", wa, shadow[wa], rx_buf[k]);
    end
    close_test("burst_read", start_err);
  endtask

  task automatic aborted_frame;
    int                start_err;
    int                k;
    logic [MEM_AW-1:0] wa;
    start_err = err_cnt;
    for (k = 0; k < 3; k++)
      random_byte(tx_buf[k]);
    send_write_frame(16'h0200, 2, 5); // third byte cut after 5 bits
    for (k = 0; k < 3; k++)
      verify_word(10'h200 + MEM_AW'(k));
    // fresh header after the cut
    send_read_frame(16'h0200, 3);
    for (k = 0; k < 3; k++)
    begin
      wa = 10'h200 + MEM_AW'(k);
      if (rx_buf[k] !== shadow[wa])
        flag_mismatch("miso byte", wa, shadow[wa], rx_buf[k]);
    end
    close_test("aborted_frame", start_err);
  endtask

  task automatic local_priority;
    int    start_err;
    byte_t d;
    start_err = err_cnt;
    random_byte(d);
    tx_buf[0] = d;
    hit_addr  = 10'h055;
    hit_data  = ~d;                  // differs from the spi byte
    hit_bit   = HDR_BITS + 7;        // last bit of data byte 0
    send_write_frame(16'h0055, 1, 0);
    hit_bit   = -1;
    shadow[hit_addr] = hit_data;     // local port wins
    verify_word(hit_addr);
    verify_word(hit_addr + 1'b1);
    close_test("local_priority", start_err);
  endtask

  initial
  begin
    sclk      = 1'b0;
    mosi      = 1'b0;
    ss        = 1'b1;
    loc_addr  = '0;
    loc_we    = 1'b0;
    loc_wdata = '0;
    lfsr      = LFSR_SEED;
    err_cnt   = 0;
    test_cnt  = 0;
    pass_cnt  = 0;
    frame_bit = 0;
    hit_bit   = -1;
    hit_addr  = '0;
    hit_data  = '0;

    check_reset_state();
    fill_ram();
    single_write();
    burst_write_wrap();
    burst_read();
    aborted_frame();
    local_priority();

    $display("summary: %0d tests, %0d passed, %0d errors", test_cnt, pass_cnt, err_cnt);
    if (err_cnt == 0 && pass_cnt == test_cnt)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  // run limit
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CLK)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("error: run did not finish within %0d clk", TIMEOUT_CLK);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule : tb_spi_ram_bridge

`default_nettype wire

// File: spi_ram_bridge.f
verilog/spi_ram_pkg.sv
verilog/spi_rw_slave.sv
verilog/spi_dp_ram.sv
verilog/spi_ram_bridge.sv
tests/tb_clk_gen.sv
tests/tb_spi_ram_bridge.sv

// File: Bender.yml
package:
  name: spi_ram_bridge

sources:
  - verilog/spi_ram_pkg.sv
  - verilog/spi_rw_slave.sv
  - verilog/spi_dp_ram.sv
  - verilog/spi_ram_bridge.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_spi_ram_bridge.sv
